/* boot_rom.sv */
/* Boot image of RomWords words, addressed by word index.
   Read data appears one cycle after req_i and holds until the next read. */
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                                        clk_i,
  input  logic                                        req_i,
  input  logic [$clog2(harness_pkg::RomWords)-1:0]    addr_i,
  output logic [harness_pkg::DataWidth-1:0]           rdata_o
);

  logic [harness_pkg::DataWidth-1:0] word;

  // Image content comes straight from the package rule
  assign word = harness_pkg::rom_word(32'(addr_i));

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= word;
    end
  end

endmodule

`default_nettype wire

/* debug_holdoff.sv */
/* Blocks the debug request for HoldoffCycles clocks after power-on reset.
   Runs on rst_ni only, so a debug reset does not restart the window. */
`timescale 1ns/1ps
`default_nettype none

module debug_holdoff #(
  parameter int unsigned HoldoffCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  // At least one bit, also for a zero window
  localparam int unsigned CntWidth =
      (HoldoffCycles > 0) ? $clog2(HoldoffCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_d, cnt_q;
  logic                holdoff;

  assign holdoff = (cnt_q != '0);

  // Count down and stick at zero
  assign cnt_d = holdoff ? cnt_q - 1'b1 : cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(HoldoffCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Boot code runs undisturbed while the window is open
  assign debug_req_o = holdoff ? 1'b0 : debug_req_i;

endmodule

`default_nettype wire

/* flist.f */
harness_pkg.sv
reset_gen.sv
debug_holdoff.sv
boot_rom.sv
ram_store.sv
mem_router.sv
harness_top.sv
tb_harness.sv

/* harness_pkg.sv */
/* Shared widths, address map and request and response types of the harness.
   The boot image is generated by rom_word. No image file is loaded. */
`default_nettype none

package harness_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 64;
  localparam int unsigned BeWidth       = DataWidth / 8;
  // Byte select bits below the word index
  localparam int unsigned WordOffset    = 3;
  localparam int unsigned ErrCountWidth = 8;

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase  = 32'h0001_0000;
  localparam int unsigned          RomWords = 32;
  // RAM length is set by the top level through NumWords
  localparam logic [AddrWidth-1:0] RamBase  = 32'h8000_0000;

  // Marker in the upper half of every boot word
  localparam logic [31:0] RomTag = 32'hB007_0000;

  // Single-word request from the core
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } mem_rsp_t;

  // Boot image word, tag plus index on top and its inverse below
  function automatic logic [DataWidth-1:0] rom_word(input int unsigned idx);
    logic [31:0] upper;
    upper = RomTag + 32'(idx);
    return {upper, ~upper};
  endfunction

endpackage

`default_nettype wire

/* harness_top.sv */
/* Harness top level. Memory logic runs on the synchronized system reset,
   the debug holdoff runs on power-on reset only. */
`timescale 1ns/1ps
`default_nettype none

module harness_top #(
  parameter int unsigned NumWords           = 1024,
  parameter int unsigned DebugHoldoffCycles = 500
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  ndmreset_i,
  input  logic                                  debug_req_i,
  input  harness_pkg::mem_req_t                 mem_req_i,
  output logic                                  sys_rst_no,
  output logic                                  debug_req_o,
  output harness_pkg::mem_rsp_t                 mem_rsp_o,
  output logic [harness_pkg::ErrCountWidth-1:0] err_count_o
);

  logic                                     rom_req;
  logic [$clog2(harness_pkg::RomWords)-1:0] rom_addr;
  logic [harness_pkg::DataWidth-1:0]        rom_rdata;

  logic                                     ram_req;
  logic                                     ram_we;
  logic [$clog2(NumWords)-1:0]              ram_addr;
  logic [harness_pkg::BeWidth-1:0]          ram_be;
  logic [harness_pkg::DataWidth-1:0]        ram_wdata;
  logic [harness_pkg::DataWidth-1:0]        ram_rdata;

  // ------------------------------------------------------------
  // Reset and debug
  // ------------------------------------------------------------
  reset_gen i_reset_gen (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_no )
  );

  debug_holdoff #(
    .HoldoffCycles ( DebugHoldoffCycles )
  ) i_debug_holdoff (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  // ------------------------------------------------------------
  // Memory path
  // ------------------------------------------------------------
  mem_router #(
    .NumWords ( NumWords )
  ) i_mem_router (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_no  ),
    .mem_req_i   ( mem_req_i   ),
    .rom_req_o   ( rom_req     ),
    .rom_addr_o  ( rom_addr    ),
    .rom_rdata_i ( rom_rdata   ),
    .ram_req_o   ( ram_req     ),
    .ram_we_o    ( ram_we      ),
    .ram_addr_o  ( ram_addr    ),
    .ram_be_o    ( ram_be      ),
    .ram_wdata_o ( ram_wdata   ),
    .ram_rdata_i ( ram_rdata   ),
    .mem_rsp_o   ( mem_rsp_o   ),
    .err_count_o ( err_count_o )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  ram_store #(
    .NumWords ( NumWords )
  ) i_ram_store (
    .clk_i   ( clk_i     ),
    .req_i   ( ram_req   ),
    .we_i    ( ram_we    ),
    .addr_i  ( ram_addr  ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

`default_nettype wire

/* mem_router.sv */
/* Routes single-word requests to boot ROM or RAM and builds the response.
   One response per request, one cycle later. No back-pressure. */
`timescale 1ns/1ps
`default_nettype none

module mem_router #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  harness_pkg::mem_req_t                    mem_req_i,
  output logic                                     rom_req_o,
  output logic [$clog2(harness_pkg::RomWords)-1:0] rom_addr_o,
  input  logic [harness_pkg::DataWidth-1:0]        rom_rdata_i,
  output logic                                     ram_req_o,
  output logic                                     ram_we_o,
  output logic [$clog2(NumWords)-1:0]              ram_addr_o,
  output logic [harness_pkg::BeWidth-1:0]          ram_be_o,
  output logic [harness_pkg::DataWidth-1:0]        ram_wdata_o,
  input  logic [harness_pkg::DataWidth-1:0]        ram_rdata_i,
  output harness_pkg::mem_rsp_t                    mem_rsp_o,
  output logic [harness_pkg::ErrCountWidth-1:0]    err_count_o
);

  localparam int unsigned RomIdxWidth = $clog2(harness_pkg::RomWords);
  localparam int unsigned RamIdxWidth = $clog2(NumWords);

  localparam logic [harness_pkg::AddrWidth-1:0] RomBytes = harness_pkg::RomWords * 8;
  localparam logic [harness_pkg::AddrWidth-1:0] RamBytes = NumWords * 8;

  // Where the registered read data comes from
  typedef enum logic [1:0] {
    SrcNone,
    SrcRom,
    SrcRam
  } src_e;

  logic [harness_pkg::AddrWidth-1:0]     rom_off, ram_off;
  logic                                  in_rom, in_ram;
  logic                                  err_d;
  src_e                                  src_d, src_q;
  logic                                  valid_q, err_q;
  logic [harness_pkg::ErrCountWidth-1:0] err_cnt_q;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  assign rom_off = mem_req_i.addr - harness_pkg::RomBase;
  assign ram_off = mem_req_i.addr - harness_pkg::RamBase;

  assign in_rom = (mem_req_i.addr >= harness_pkg::RomBase) && (rom_off < RomBytes);
  assign in_ram = (mem_req_i.addr >= harness_pkg::RamBase) && (ram_off < RamBytes);

  // ROM only sees reads, a ROM write falls through to the error path
  assign rom_req_o  = mem_req_i.req & in_rom & ~mem_req_i.we;
  assign rom_addr_o = rom_off[harness_pkg::WordOffset +: RomIdxWidth];

  assign ram_req_o   = mem_req_i.req & in_ram;
  assign ram_we_o    = mem_req_i.we;
  assign ram_addr_o  = ram_off[harness_pkg::WordOffset +: RamIdxWidth];
  assign ram_be_o    = mem_req_i.be;
  assign ram_wdata_o = mem_req_i.wdata;

  assign err_d = mem_req_i.req & ~rom_req_o & ~ram_req_o;

  always_comb begin
    if (rom_req_o) begin
      src_d = SrcRom;
    end else if (ram_req_o && !mem_req_i.we) begin
      src_d = SrcRam;
    end else begin
      src_d = SrcNone;
    end
  end

  // ------------------------------------------------------------
  // Response stage
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      err_q     <= 1'b0;
      src_q     <= SrcNone;
      err_cnt_q <= '0;
    end else begin
      valid_q <= mem_req_i.req;
      err_q   <= err_d;
      src_q   <= src_d;
      // Saturating, counted as the error response goes out
      if (err_d && !(&err_cnt_q)) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    mem_rsp_o.rvalid = valid_q;
    mem_rsp_o.err    = err_q;
    unique case (src_q)
      SrcRom:  mem_rsp_o.rdata = rom_rdata_i;
      SrcRam:  mem_rsp_o.rdata = ram_rdata_i;
      default: mem_rsp_o.rdata = '0;
    endcase
  end

  assign err_count_o = err_cnt_q;

endmodule

`default_nettype wire

/* ram_store.sv */
/* Word RAM with byte enables and one cycle read latency.
   Contents are not cleared by any reset. */
`timescale 1ns/1ps
`default_nettype none

module ram_store #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [$clog2(NumWords)-1:0]         addr_i,
  input  logic [harness_pkg::BeWidth-1:0]     be_i,
  input  logic [harness_pkg::DataWidth-1:0]   wdata_i,
  output logic [harness_pkg::DataWidth-1:0]   rdata_o
);

  logic [harness_pkg::DataWidth-1:0] mem_q [NumWords];

  // ------------------------------------------------------------
  // Write port, one byte lane per enable bit
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned i = 0; i < harness_pkg::BeWidth; i++) begin
        if (be_i[i]) begin
          mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------
  // Writes leave the read register untouched
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

/* reset_gen.sv */
/* System reset, asserted asynchronously and released on clk_i.
   Debug reset (ndmreset_i) is active high. */
`timescale 1ns/1ps
`default_nettype none

module reset_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // Either source pulls the system into reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      // Shift a one through both stages
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the harness testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_harness \
  -f flist.f -o tb_harness_sim > build.log 2>&1 \
  && ./obj_dir/tb_harness_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat build.log; exit 1; }

cat sim.log
grep -q "TEST PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tb_harness.sv */
/* Directed testbench for harness_top with a short debug holdoff.
   RAM starts undefined, so every tested word is fully written first. */
`timescale 1ns/1ps
`default_nettype none

module tb_harness;

  localparam int unsigned NumWords      = 1024;
  localparam int unsigned HoldoffCycles = 20;
  // Tests take about 120 cycles, the rest is margin
  localparam int unsigned TimeoutCycles = 2000;
  localparam int unsigned ErrCountMax   = (1 << harness_pkg::ErrCountWidth) - 1;

  logic                                  clk_i;
  logic                                  rst_ni;
  logic                                  ndmreset_i;
  logic                                  debug_req_i;
  harness_pkg::mem_req_t                 mem_req_i;
  logic                                  sys_rst_no;
  logic                                  debug_req_o;
  harness_pkg::mem_rsp_t                 mem_rsp_o;
  logic [harness_pkg::ErrCountWidth-1:0] err_count_o;

  int unsigned checks = 0;
  int unsigned errors = 0;
  // Error responses since the last system reset, saturating like the counter
  int unsigned expected_errors = 0;

  // Reference copy of the RAM words the tests touch
  logic [63:0] ram_model [int unsigned];
  int unsigned ram_words [5] = '{0, 1, 2, 77, 1023};
  int unsigned rom_indices [6] = '{0, 1, 5, 17, 30, 31};

  harness_top #(
    .NumWords           ( NumWords      ),
    .DebugHoldoffCycles ( HoldoffCycles )
  ) i_dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .mem_req_i   ( mem_req_i   ),
    .sys_rst_no  ( sys_rst_no  ),
    .debug_req_o ( debug_req_o ),
    .mem_rsp_o   ( mem_rsp_o   ),
    .err_count_o ( err_count_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the tests did not finish", TimeoutCycles);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Check helpers and reference rules
  // ------------------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Tag plus index on top, its inverse below
  function automatic logic [63:0] expected_boot_word(input int unsigned idx);
    logic [31:0] upper;
    upper = harness_pkg::RomTag + idx;
    return {upper, ~upper};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0]  be);
    logic [63:0] result;
    result = old_word;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic harness_pkg::mem_req_t build_request(input logic        we,
                                                          input logic [31:0] addr,
                                                          input logic [7:0]  be,
                                                          input logic [63:0] wdata);
    harness_pkg::mem_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic logic [31:0] ram_addr(input int unsigned word);
    return harness_pkg::RamBase + (word << harness_pkg::WordOffset);
  endfunction

  // One request, one idle cycle, then the response is checked
  task automatic run_access(input logic we, input logic [31:0] addr, input logic [7:0] be,
                            input logic [63:0] wdata, input logic exp_err,
                            input logic [63:0] exp_rdata);
    @(posedge clk_i);
    mem_req_i <= build_request(we, addr, be, wdata);
    @(posedge clk_i);
    mem_req_i <= '0;
    @(negedge clk_i);
    check_bit("mem_rsp_o.rvalid", mem_rsp_o.rvalid, 1'b1);
    check_bit("mem_rsp_o.err", mem_rsp_o.err, exp_err);
    check_word("mem_rsp_o.rdata", mem_rsp_o.rdata, exp_rdata);
    if (exp_err && expected_errors < ErrCountMax) begin
      expected_errors++;
    end
  endtask

  task automatic verify_ram_contents();
    foreach (ram_words[i]) begin
      run_access(1'b0, ram_addr(ram_words[i]), 8'h00, 64'h0, 1'b0, ram_model[ram_words[i]]);
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic test_debug_holdoff();
    logic seen;
    for (int n = 1; n <= 18; n++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_bit("debug_req_o", debug_req_o, 1'b0);
    end
    seen = 1'b0;
    for (int n = 19; n <= 22 && !seen; n++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      seen = debug_req_o;
    end
    checks++;
    assert (seen) else begin
      $display("debug_req_o did not go high within 22 cycles after power-on reset release");
      errors++;
    end
  endtask

  task automatic test_rom_reads();
    for (int k = 0; k <= 6; k++) begin
      @(posedge clk_i);
      if (k < 6) begin
        mem_req_i <= build_request(1'b0, harness_pkg::RomBase +
                                   (rom_indices[k] << harness_pkg::WordOffset), 8'h00, 64'h0);
      end else begin
        mem_req_i <= '0;
      end
      @(negedge clk_i);
      if (k > 0) begin
        check_bit("mem_rsp_o.rvalid", mem_rsp_o.rvalid, 1'b1);
        check_bit("mem_rsp_o.err", mem_rsp_o.err, 1'b0);
        check_word("mem_rsp_o.rdata", mem_rsp_o.rdata, expected_boot_word(rom_indices[k-1]));
      end
    end
    @(negedge clk_i);
    check_bit("mem_rsp_o.rvalid", mem_rsp_o.rvalid, 1'b0);
  endtask

  task automatic test_ram_write_read();
    logic [63:0] data;
    logic [7:0]  be;
    foreach (ram_words[i]) begin
      data = {$urandom, $urandom};
      run_access(1'b1, ram_addr(ram_words[i]), 8'hFF, data, 1'b0, 64'h0);
      ram_model[ram_words[i]] = data;
    end
    repeat (2) begin
      foreach (ram_words[i]) begin
        data = {$urandom, $urandom};
        be   = 8'($urandom);
        run_access(1'b1, ram_addr(ram_words[i]), be, data, 1'b0, 64'h0);
        ram_model[ram_words[i]] = merge_bytes(ram_model[ram_words[i]], data, be);
      end
    end
    verify_ram_contents();
  endtask

  task automatic test_error_responses();
    run_access(1'b1, harness_pkg::RomBase + 32'h8, 8'hFF, 64'hDEAD_BEEF_0BAD_F00D, 1'b1, 64'h0);
    run_access(1'b0, 32'h4000_0000, 8'h00, 64'h0, 1'b1, 64'h0);
    // Just past the RAM end, would alias word 0 if the decode wrapped
    run_access(1'b1, ram_addr(NumWords), 8'hFF, 64'h1234_5678_9ABC_DEF0, 1'b1, 64'h0);
    run_access(1'b0, harness_pkg::RomBase - 32'h8, 8'h00, 64'h0, 1'b1, 64'h0);
    check_word("err_count_o", 64'(err_count_o), 64'(expected_errors));
    verify_ram_contents();
  endtask

  task automatic test_debug_reset();
    logic released;
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    @(negedge clk_i);
    check_bit("sys_rst_no", sys_rst_no, 1'b0);
    check_word("err_count_o", 64'(err_count_o), 64'h0);
    expected_errors = 0;
    // Holdoff only restarts on power-on reset
    check_bit("debug_req_o", debug_req_o, 1'b1);
    repeat (2) @(posedge clk_i);
    ndmreset_i <= 1'b0;
    released = 1'b0;
    for (int n = 0; n < 2 && !released; n++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      released = sys_rst_no;
    end
    checks++;
    assert (released) else begin
      $display("sys_rst_no stayed low for more than two cycles after debug reset release");
      errors++;
    end
    verify_ram_contents();
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rst_ni      = 1'b0;
    ndmreset_i  = 1'b0;
    debug_req_i = 1'b1;
    mem_req_i   = '0;
    void'($urandom(27));
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_debug_holdoff();
    test_rom_reads();
    test_ram_write_read();
    test_error_responses();
    test_debug_reset();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
